// File: icache_top.f
+incdir+.
icache_pkg.sv
icache_way_array.sv
icache_lru.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_clock.sv
tb_axi_mem.sv
tb_icache.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILE_LIST ?= icache_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

    localparam logic [31:0] PATTERN_KEY = 32'h5a3c_96e1;
    localparam logic [31:0] ERR_BASE = 32'h0000_8000;
    localparam logic [31:0] ERR_SIZE = 32'h0000_0040;   // two lines
    localparam int WAIT_LIMIT = 200;
    localparam int WAYS = icache_pkg::WAYS;
    localparam int WORDS = icache_pkg::WORDS;

    logic clk;
    logic reset;
    logic req_valid;
    icache_pkg::fetch_req_t req;
    logic resp_valid;
    icache_pkg::fetch_resp_t resp;
    logic [31:0] axi_araddr;
    logic axi_arvalid;
    logic axi_arready;
    logic [31:0] axi_rdata;
    logic [1:0] axi_rresp;
    logic axi_rvalid;
    logic axi_rready;

    logic started;
    logic exp_hit;
    logic exp_err;
    logic [31:0] exp_inst;
    logic [31:0] exp_line;
    logic [31:0] ar_addr_seen;
    int cycles_since_req = 0;
    int ar_count = 0;
    int beat_count = 0;
    int error_count = 0;
    int timeout_count = 0;
    int request_count = 0;

    // reference model of tags and age ranks
    logic model_valid [icache_pkg::SETS][WAYS];
    logic [icache_pkg::TAG_W-1:0] model_tag [icache_pkg::SETS][WAYS];
    int model_age [icache_pkg::SETS][WAYS];

    tb_clock u_clock (.clk(clk), .reset(reset));

    icache_top uut (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req(req),
        .resp_valid(resp_valid), .resp(resp),
        .axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
        .axi_rdata(axi_rdata), .axi_rresp(axi_rresp), .axi_rvalid(axi_rvalid),
        .axi_rready(axi_rready)
    );

    tb_axi_mem #(
        .pattern_key(PATTERN_KEY), .err_base(ERR_BASE), .err_size(ERR_SIZE)
    ) u_mem (
        .clk(clk), .reset(reset), .araddr(axi_araddr), .arvalid(axi_arvalid),
        .arready(axi_arready), .rdata(axi_rdata), .rresp(axi_rresp),
        .rvalid(axi_rvalid), .rready(axi_rready)
    );

    // bus activity since the last request
    always @(posedge clk) begin
        if (req_valid) begin
            cycles_since_req <= 0;
            ar_count <= 0;
            beat_count <= 0;
        end else begin
            cycles_since_req <= cycles_since_req + 1;
            if (axi_arvalid && axi_arready) begin
                ar_count <= ar_count + 1;
                ar_addr_seen <= axi_araddr;
            end
            if (axi_rvalid && axi_rready) beat_count <= beat_count + 1;
        end
    end

    function automatic void record_failure(input string what);
        error_count++;
        $display("FAIL %0t: %s", $time, what);
    endfunction

    // sampled on the falling edge, where nothing moves
    quiet_after_reset: assert property (@(negedge clk)
        (!reset && !started) |-> (!resp_valid && !axi_arvalid && !axi_rready))
        else record_failure("fetch or axi outputs active before the first request");

    answer_word: assert property (@(negedge clk)
        (resp_valid && !resp.err) |-> (resp.inst == exp_inst))
        else record_failure($sformatf("word %h, expected %h", resp.inst, exp_inst));

    answer_error: assert property (@(negedge clk) resp_valid |-> (resp.err == exp_err))
        else record_failure($sformatf("error bit %b, expected %b", resp.err, exp_err));

    hit_timing: assert property (@(negedge clk)
        (resp_valid && exp_hit) |-> (cycles_since_req == 2 && ar_count == 0))
        else record_failure($sformatf("hit answered after %0d cycles with %0d reads",
                                      cycles_since_req, ar_count));

    miss_refill: assert property (@(negedge clk)
        (resp_valid && !exp_hit) |->
        (ar_count == 1 && ar_addr_seen == exp_line && beat_count == WORDS))
        else record_failure($sformatf("miss saw %0d reads at %h and %0d beats, line %h",
                                      ar_count, ar_addr_seen, beat_count, exp_line));

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return (32'(tag) << (icache_pkg::INDEX_W + icache_pkg::OFFSET_W)) |
               (32'(set) << icache_pkg::OFFSET_W) | (32'(word) << 2);
    endfunction

    task automatic model_touch(input int set, input int way);
        int old_age;
        old_age = model_age[set][way];
        for (int w = 0; w < WAYS; w++) begin
            if (model_age[set][w] > old_age) model_age[set][w]--;
        end
        model_age[set][way] = WAYS - 1;   // now most recent
    endtask

    function automatic int model_victim(input int set);
        int victim;
        victim = -1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!model_valid[set][w]) victim = w;
        end
        if (victim < 0) begin
            for (int w = 0; w < WAYS; w++) begin
                if (model_age[set][w] == 0) victim = w;
            end
        end
        return victim;
    endfunction

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
    endtask

    task automatic fetch(input logic [31:0] addr);
        int set;
        int way;
        int waited;
        logic [icache_pkg::TAG_W-1:0] tag;
        if (timeout_count > 0) begin
            return;   // cache stuck on an earlier request
        end
        set = int'(addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W]);
        tag = addr[31 -: icache_pkg::TAG_W];
        way = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tag) way = w;
        end
        exp_hit = (way >= 0);
        exp_inst = {addr[31:2], 2'b00} ^ PATTERN_KEY;
        exp_err = (addr >= ERR_BASE) && (addr < ERR_BASE + ERR_SIZE);
        exp_line = addr & ~32'(WORDS * 4 - 1);
        started = 1'b1;
        req.addr = addr;
        req_valid = 1'b1;
        @(posedge clk);
        #1 req_valid = 1'b0;
        waited = 0;
        while (!resp_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1 waited++;
        end
        if (!resp_valid) begin
            report_timeout($sformatf("the answer to %h", addr));
        end else begin
            if (exp_hit) begin
                model_touch(set, way);
            end else if (!exp_err) begin
                way = model_victim(set);   // a bad line is never installed
                model_valid[set][way] = 1'b1;
                model_tag[set][way] = tag;
                model_touch(set, way);
            end
            request_count++;
            @(posedge clk);
            #1;   // checks see this answer before the next request
        end
    endtask

    initial begin
        int waited;
        req_valid = 1'b0;
        req = '0;
        started = 1'b0;
        exp_hit = 1'b0;
        exp_err = 1'b0;
        exp_inst = '0;
        exp_line = '0;
        for (int s = 0; s < icache_pkg::SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_age[s][w] = w;
            end
        end
        waited = 0;
        while (reset !== 1'b0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1 waited++;
        end
        if (reset !== 1'b0) begin
            report_timeout("reset release");
        end else begin
            repeat (4) @(posedge clk);
            #1;
            // one line word by word, first a miss then hits
            for (int w = 0; w < WORDS; w++) fetch(make_addr(1, 3, w));
            fetch(make_addr(1, 3, 1) + 32'd3);   // byte address inside a word
            // fill set 5, then touch the ways newest last
            for (int t = 0; t < WAYS; t++) fetch(make_addr(10 + t, 5, 0));
            for (int t = WAYS - 1; t >= 0; t--) fetch(make_addr(10 + t, 5, t % WORDS));
            fetch(make_addr(10 + WAYS, 5, 2));   // pushes out the oldest tag
            for (int t = 0; t < WAYS - 1; t++) fetch(make_addr(10 + t, 5, 1));
            fetch(make_addr(10 + WAYS, 5, 3));
            fetch(make_addr(10 + WAYS - 1, 5, 0));
            // error window twice, then a clean line in the same set
            fetch(ERR_BASE + 32'h8);
            fetch(ERR_BASE + 32'h8);
            fetch(make_addr(7, 0, 4));
            for (int i = 0; i < 48; i++) begin
                fetch(make_addr(2 + (i * 5) % 3, (i * 7) % icache_pkg::SETS, (i * 3) % WORDS));
            end
        end
        $display("requests %0d, errors %0d, timeouts %0d",
                 request_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter logic [31:0] pattern_key = 32'h0,
    parameter logic [31:0] err_base = 32'h0,
    parameter logic [31:0] err_size = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef enum logic [2:0] {M_IDLE, M_AR_STALL, M_AR_TAKE, M_GAP, M_BEAT} mem_state_t;

    mem_state_t  st;
    logic [31:0] lfsr;
    logic [31:0] line_addr;
    logic [1:0]  stall;
    logic [1:0]  gap;
    logic        take;     // rready as the next edge sees it
    int          beat_idx;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [1:0] random_two_bits();
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
        return bits;
    endfunction

    task automatic accept_address();
        arready = 1'b1;
        line_addr = araddr;
        st = M_AR_TAKE;
    endtask

    task automatic present_beat();
        logic [31:0] addr;
        addr = line_addr + 32'(4 * beat_idx);
        rvalid = 1'b1;
        rdata = {addr[31:2], 2'b00} ^ pattern_key;
        // bad third beat inside the window
        if (line_addr >= err_base && line_addr < err_base + err_size && beat_idx == 2) begin
            rresp = icache_pkg::SLVERR;
        end else begin
            rresp = icache_pkg::OKAY;
        end
        take = rready;
        st = M_BEAT;
    endtask

    task automatic start_gap();
        gap = random_two_bits();
        if (gap == 2'd0) begin
            present_beat();
        end else begin
            rvalid = 1'b0;
            st = M_GAP;
        end
    endtask

    initial begin
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = '0;
        take = 1'b0;
        beat_idx = 0;
        st = M_IDLE;
        lfsr = 32'h46d5;
        forever begin
            @(posedge clk);
            #1;
            if (reset) begin
                arready = 1'b0;
                rvalid = 1'b0;
                st = M_IDLE;
            end else begin
                case (st)
                    M_IDLE: begin
                        if (arvalid) begin
                            stall = random_two_bits();
                            if (stall == 2'd0) accept_address();
                            else st = M_AR_STALL;
                        end
                    end
                    M_AR_STALL: begin
                        stall = stall - 1'b1;
                        if (stall == 2'd0) accept_address();
                    end
                    M_AR_TAKE: begin
                        arready = 1'b0;   // address went on the last edge
                        beat_idx = 0;
                        start_gap();
                    end
                    M_GAP: begin
                        gap = gap - 1'b1;
                        if (gap == 2'd0) present_beat();
                    end
                    M_BEAT: begin
                        if (take) begin
                            beat_idx++;
                            if (beat_idx == icache_pkg::WORDS) begin
                                rvalid = 1'b0;
                                st = M_IDLE;
                            end else begin
                                start_gap();
                            end
                        end else begin
                            take = rready;
                        end
                    end
                    default: st = M_IDLE;
                endcase
            end
        end
    end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;   // two edges in reset
    end

endmodule

// File: icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  icache_pkg::fetch_req_t        req,
    output logic                          resp_valid,
    output icache_pkg::fetch_resp_t       resp,
    output logic [icache_pkg::ADDR_W-1:0] axi_araddr,
    output logic                          axi_arvalid,
    input  logic                          axi_arready,
    input  logic [31:0]                   axi_rdata,
    input  logic [1:0]                    axi_rresp,
    input  logic                          axi_rvalid,
    output logic                          axi_rready
);

    logic [icache_pkg::INDEX_W-1:0]                rd_index;
    logic                                          wr_en;
    logic [icache_pkg::INDEX_W-1:0]                wr_index;
    logic [icache_pkg::WAY_W-1:0]                  wr_way;
    icache_pkg::tag_entry_t                        wr_tag;
    icache_pkg::line_t                             wr_line;
    icache_pkg::tag_entry_t [icache_pkg::WAYS-1:0] tag_rd;
    icache_pkg::line_t [icache_pkg::WAYS-1:0]      line_rd;
    logic                                          touch;
    logic [icache_pkg::INDEX_W-1:0]                touch_index;
    logic [icache_pkg::WAY_W-1:0]                  touch_way;
    logic [icache_pkg::WAYS-1:0]                   set_valid;
    logic [icache_pkg::WAY_W-1:0]                  victim_way;
    logic                                          refill_start;
    icache_pkg::axi_ar_t                           refill_ar;
    logic                                          refill_done;
    icache_pkg::line_t                             refill_line;
    logic                                          refill_err;

    icache_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req(req),
        .tag_rd(tag_rd), .line_rd(line_rd), .victim_way(victim_way),
        .refill_done(refill_done), .refill_line(refill_line), .refill_err(refill_err),
        .rd_index(rd_index), .wr_en(wr_en), .wr_index(wr_index), .wr_way(wr_way),
        .wr_tag(wr_tag), .wr_line(wr_line),
        .touch(touch), .touch_index(touch_index), .touch_way(touch_way),
        .set_valid(set_valid), .refill_start(refill_start), .refill_ar(refill_ar),
        .resp_valid(resp_valid), .resp(resp)
    );

    icache_way_array #(
        .entry_t(icache_pkg::tag_entry_t), .ways(icache_pkg::WAYS), .sets(icache_pkg::SETS)
    ) u_tag_array (
        .clk(clk), .reset(reset), .rd_index(rd_index),
        .wr_en(wr_en), .wr_index(wr_index), .wr_way(wr_way), .wr_entry(wr_tag),
        .rd_entries(tag_rd)
    );

    icache_way_array #(
        .entry_t(icache_pkg::line_t), .ways(icache_pkg::WAYS), .sets(icache_pkg::SETS)
    ) u_line_array (
        .clk(clk), .reset(reset), .rd_index(rd_index),
        .wr_en(wr_en), .wr_index(wr_index), .wr_way(wr_way), .wr_entry(wr_line),
        .rd_entries(line_rd)
    );

    // victim is looked up in the set under request
    icache_lru u_lru (
        .clk(clk), .reset(reset),
        .touch(touch), .touch_index(touch_index), .touch_way(touch_way),
        .victim_index(rd_index), .set_valid(set_valid), .victim_way(victim_way)
    );

    icache_refill u_refill (
        .clk(clk), .reset(reset),
        .start(refill_start), .start_ar(refill_ar),
        .axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
        .axi_rvalid(axi_rvalid), .axi_rready(axi_rready),
        .axi_rdata(axi_rdata), .axi_rresp(axi_rresp),
        .done(refill_done), .line(refill_line), .err(refill_err)
    );

endmodule

// File: icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          req_valid,
    input  icache_pkg::fetch_req_t                        req,
    input  icache_pkg::tag_entry_t [icache_pkg::WAYS-1:0] tag_rd,
    input  icache_pkg::line_t [icache_pkg::WAYS-1:0]      line_rd,
    input  logic [icache_pkg::WAY_W-1:0]                  victim_way,
    input  logic                                          refill_done,
    input  icache_pkg::line_t                             refill_line,
    input  logic                                          refill_err,
    output logic [icache_pkg::INDEX_W-1:0]                rd_index,
    output logic                                          wr_en,
    output logic [icache_pkg::INDEX_W-1:0]                wr_index,
    output logic [icache_pkg::WAY_W-1:0]                  wr_way,
    output icache_pkg::tag_entry_t                        wr_tag,
    output icache_pkg::line_t                             wr_line,
    output logic                                          touch,
    output logic [icache_pkg::INDEX_W-1:0]                touch_index,
    output logic [icache_pkg::WAY_W-1:0]                  touch_way,
    output logic [icache_pkg::WAYS-1:0]                   set_valid,
    output logic                                          refill_start,
    output icache_pkg::axi_ar_t                           refill_ar,
    output logic                                          resp_valid,
    output icache_pkg::fetch_resp_t                       resp
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,    // array read under way
        S_COMPARE,
        S_REFILL
    } state_t;

    state_t                         state;
    icache_pkg::fetch_req_t         req_q;
    logic [icache_pkg::TAG_W-1:0]   req_tag;
    logic [icache_pkg::INDEX_W-1:0] req_index;
    logic [icache_pkg::WORD_W-1:0]  word_sel;
    logic                           hit;
    logic [icache_pkg::WAY_W-1:0]   hit_way;
    logic [icache_pkg::WAYS-1:0]    valid_q;
    logic                           install;

    assign req_tag = req_q.addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign req_index = req_q.addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign word_sel = req_q.addr[2 +: icache_pkg::WORD_W];

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (tag_rd[w].valid && tag_rd[w].tag == req_tag) begin
                hit = 1'b1;
                hit_way = icache_pkg::WAY_W'(w);
            end
        end
    end

    // install only a clean line
    assign install = (state == S_REFILL) && refill_done && !refill_err;

    assign rd_index = req_index;
    assign wr_en = install;
    assign wr_index = req_index;
    assign wr_way = victim_way;
    assign wr_tag = '{valid: 1'b1, tag: req_tag};
    assign wr_line = refill_line;
    assign touch = ((state == S_COMPARE) && hit) || install;
    assign touch_index = req_index;
    assign touch_way = (state == S_COMPARE) ? hit_way : victim_way;
    assign set_valid = valid_q;
    assign refill_start = (state == S_COMPARE) && !hit;   // arvalid follows next edge
    assign refill_ar.addr = {req_q.addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                             {icache_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: state <= S_COMPARE;
                S_COMPARE: begin
                    if (hit) begin
                        resp_valid <= 1'b1;   // two cycles after the request
                        state <= S_IDLE;
                    end else begin
                        state <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (refill_done) begin
                        resp_valid <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == S_COMPARE) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                valid_q[w] <= tag_rd[w].valid;   // kept for victim choice
            end
            resp.inst <= line_rd[hit_way].words[word_sel];
            resp.err <= 1'b0;
        end else if (state == S_REFILL) begin
            resp.inst <= refill_line.words[word_sel];   // straight from the buffer
            resp.err <= refill_err;
        end
    end

endmodule

// File: icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  icache_pkg::axi_ar_t             start_ar,
    output logic [icache_pkg::ADDR_W-1:0]   axi_araddr,
    output logic                            axi_arvalid,
    input  logic                            axi_arready,
    input  logic                            axi_rvalid,
    output logic                            axi_rready,
    input  logic [31:0]                     axi_rdata,
    input  logic [1:0]                      axi_rresp,
    output logic                            done,
    output icache_pkg::line_t               line,
    output logic                            err
);

    logic [icache_pkg::WORD_W-1:0] beat_cnt;
    logic                          beat;
    logic                          last_beat;
    logic                          beat_err;

    assign beat = axi_rvalid && axi_rready;
    assign last_beat = beat_cnt == icache_pkg::WORD_W'(icache_pkg::WORDS - 1);
    assign beat_err = axi_rresp != icache_pkg::OKAY;   // any non-okay code

    // handshake and sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            axi_arvalid <= 1'b0;
            axi_rready <= 1'b0;
            done <= 1'b0;
            beat_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                axi_arvalid <= 1'b1;
                beat_cnt <= '0;
            end
            if (axi_arvalid && axi_arready) begin
                axi_arvalid <= 1'b0;   // address taken
                axi_rready <= 1'b1;
            end
            if (beat) begin
                if (last_beat) begin
                    axi_rready <= 1'b0;
                    done <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // address, line buffer and error flag
    always_ff @(posedge clk) begin
        if (start) begin
            axi_araddr <= start_ar.addr;   // held until arready
            err <= 1'b0;
        end
        if (beat) begin
            line.words[beat_cnt] <= axi_rdata;
            if (beat_err) begin
                err <= 1'b1;   // one bad beat spoils the line
            end
        end
    end

endmodule

// File: icache_lru.sv
`timescale 1ns/1ps

module icache_lru (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             touch,
    input  logic [icache_pkg::INDEX_W-1:0]   touch_index,
    input  logic [icache_pkg::WAY_W-1:0]     touch_way,
    input  logic [icache_pkg::INDEX_W-1:0]   victim_index,
    input  logic [icache_pkg::WAYS-1:0]      set_valid,
    output logic [icache_pkg::WAY_W-1:0]     victim_way
);

    // age rank per way, WAYS-1 is most recently used
    logic [icache_pkg::AGE_W-1:0] age [icache_pkg::SETS][icache_pkg::WAYS];
    logic [icache_pkg::AGE_W-1:0] touched_age;
    logic                         found_invalid;

    assign touched_age = age[touch_index][touch_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < icache_pkg::SETS; s++) begin
                for (int w = 0; w < icache_pkg::WAYS; w++) begin
                    age[s][w] <= icache_pkg::AGE_W'(w);   // start ranked by way number
                end
            end
        end else if (touch) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                if (icache_pkg::WAY_W'(w) == touch_way) begin
                    age[touch_index][w] <= icache_pkg::AGE_W'(icache_pkg::WAYS - 1);
                end else if (age[touch_index][w] > touched_age) begin
                    // ways that were newer shift down one rank
                    age[touch_index][w] <= age[touch_index][w] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        victim_way = '0;
        found_invalid = 1'b0;
        // an empty way wins, lowest number first
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (!found_invalid && !set_valid[w]) begin
                victim_way = icache_pkg::WAY_W'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                if (age[victim_index][w] == '0) begin
                    victim_way = icache_pkg::WAY_W'(w);   // least recently used
                end
            end
        end
    end

endmodule

// File: icache_way_array.sv
`timescale 1ns/1ps

module icache_way_array #(
    parameter type entry_t = logic [31:0],
    parameter int ways = 2,
    parameter int sets = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [$clog2(sets)-1:0] rd_index,
    input  logic                    wr_en,
    input  logic [$clog2(sets)-1:0] wr_index,
    input  logic [$clog2(ways)-1:0] wr_way,
    input  entry_t                  wr_entry,
    output entry_t [ways-1:0]       rd_entries
);

    entry_t mem [sets][ways];

    always_ff @(posedge clk) begin
        if (reset) begin
            // cleared so every tag entry comes up invalid
            for (int s = 0; s < sets; s++) begin
                for (int w = 0; w < ways; w++) begin
                    mem[s][w] <= '0;
                end
            end
            rd_entries <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_index][wr_way] <= wr_entry;
            end
            // all ways of the set, old data on a same-cycle write
            for (int w = 0; w < ways; w++) begin
                rd_entries[w] <= mem[rd_index][w];
            end
        end
    end

endmodule

// File: icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    localparam int ADDR_W = `ICACHE_ADDR_W;
    localparam int WAYS = `ICACHE_WAYS;
    localparam int SETS = `ICACHE_SIZE_BYTES / (`ICACHE_LINE_BYTES * `ICACHE_WAYS);
    localparam int WORDS = `ICACHE_LINE_BYTES / 4;   // 32-bit words per line
    localparam int INDEX_W = $clog2(SETS);
    localparam int OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
    localparam int WORD_W = OFFSET_W - 2;              // word select within a line
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W = $clog2(WAYS);
    localparam int AGE_W = $clog2(WAYS);               // rank 0 is least recent

    typedef struct packed {
        logic [ADDR_W-1:0] addr;      // byte address
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] inst;
        logic        err;
    } fetch_resp_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [WORDS-1:0][31:0] words;   // word 0 at the line base
    } line_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;      // line aligned
    } axi_ar_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

// File: icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry, all powers of two
`define ICACHE_SIZE_BYTES 1024

// bytes per line, at least two words
`define ICACHE_LINE_BYTES 32

// associativity, at least two ways
`define ICACHE_WAYS 2

// fetch and axi address width
`define ICACHE_ADDR_W 32

`endif
